/* flist.f */
design/sched_pkg.sv
design/x_tile_walker.sv
design/stream_launch.sv
design/dequant_offset_gen.sv
design/memory_scheduler.sv
verification/memory_scheduler_sva.sv
verification/memory_scheduler_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" && \
verilator --binary --timing --assert -f flist.f --top-module memory_scheduler_tb \
  -o memory_scheduler_sim && ./obj_dir/memory_scheduler_sim || exit 1

/* verification/memory_scheduler_tb.sv */
// Directed testbench for the memory scheduler, compiled from flist.f and run by run.sh
`timescale 1ns/1ps
`default_nettype none

module memory_scheduler_tb;
  import sched_pkg::*;

  // Whole test sequence runs in roughly a hundred cycles
  localparam int TIMEOUT_CYCLES = 2000;

  logic              clk_i, rst_ni, clear_i, sched_rst_i;
  logic [ADDR_W-1:0] x_addr_i, x_rows_offs_i, w_addr_i, scales_addr_i;
  logic [ITER_W-1:0] x_col_iters_i, x_row_iters_i, w_iters_i, tot_x_read_i;
  logic [ITER_W-1:0] w_d0_stride_i, row_data_i;
  logic [LEN_W-1:0]  x_leftover_i, x_tot_len_o;
  logic              accumulate_i, dequant_en_i, first_load_i, idle_i;
  qint_fmt_e         qint_fmt_i;
  logic              x_done_i, x_ready_start_i, w_ready_start_i, y_ready_start_i;
  logic              z_ready_start_i, dq_ready_start_i;
  logic              gidx_valid_i, row_valid_i, scales_ready_i, zeros_ready_i, wq_ready_i;
  logic [GID_W:0]    gidx_data_i;
  logic              gidx_ready_o, row_ready_o, gidx_offs_valid_o, gidx_skip_o, wq_valid_o;
  logic [ADDR_W-1:0] scales_offs_o, zeros_offs_o, wq_offs_o, x_base_addr_o, w_base_addr_o;
  logic              x_req_start_o, w_req_start_o, y_req_start_o, z_req_start_o;
  logic              dq_req_start_o, ignore_o;
  int                cycle_cnt = 0;

  memory_scheduler UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Timeout");
    end
  end

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic expect_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL time=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic expect_bit(input string name, input logic got, input logic exp);
    expect_word(name, 32'(got), 32'(exp));
  endtask

  // Requests packed as {x, w, y, z, dq}
  task automatic expect_requests(input logic [4:0] exp);
    expect_word("{x,w,y,z,dq}_req_start_o", 32'({x_req_start_o, w_req_start_o,
                y_req_start_o, z_req_start_o, dq_req_start_o}), 32'(exp));
  endtask

  // Handshake outputs packed as {gidx_offs_valid, gidx_ready, wq_valid, row_ready}
  task automatic expect_handshake(input logic [3:0] exp);
    expect_word("{gidx_offs_valid,gidx_ready,wq_valid,row_ready}_o",
                32'({gidx_offs_valid_o, gidx_ready_o, wq_valid_o, row_ready_o}), 32'(exp));
  endtask

  task automatic pulse_done();
    x_done_i = 1'b1;
    next_cycle();
    x_done_i = 1'b0;
  endtask

  task automatic restart_walker(input logic use_clear);
    clear_i     = use_clear;
    sched_rst_i = !use_clear;
    next_cycle();
    clear_i     = 1'b0;
    sched_rst_i = 1'b0;
  endtask

  // Narrower formats divide the stride further
  function automatic int fmt_shift(input qint_fmt_e fmt);
    case (fmt)
      QINT_2:  return 3;
      QINT_4:  return 2;
      default: return 1;
    endcase
  endfunction

  task automatic reset_state();
    @(negedge clk_i);
    expect_word("x_base_addr_o", x_base_addr_o, x_addr_i);
    expect_word("x_tot_len_o", 32'(x_tot_len_o), ARRAY_W);
    expect_requests(5'b00000);
    next_cycle();
  endtask

  task automatic column_walk();
    logic [ADDR_W-1:0] exp_addr;
    for (int k = 1; k <= 6; k++) begin
      pulse_done();
      @(negedge clk_i);
      // Three column blocks per weight block, two weight blocks per row block
      exp_addr = x_addr_i + (k % 3) * MEM_JMP + (k / 6) * x_rows_offs_i;
      expect_word("x_base_addr_o", x_base_addr_o, exp_addr);
      next_cycle();
    end
    restart_walker(1'b0);
    @(negedge clk_i);
    expect_word("x_base_addr_o", x_base_addr_o, x_addr_i);
    next_cycle();
  endtask

  task automatic leftover_rows();
    logic [31:0] exp_len;
    x_leftover_i = LEN_W'(5);
    @(negedge clk_i);
    expect_word("x_tot_len_o", 32'(x_tot_len_o), ARRAY_W);
    next_cycle();
    for (int k = 1; k <= 12; k++) begin
      pulse_done();
      @(negedge clk_i);
      exp_len = (((k / 6) % 2) == 1) ? 32'd5 : ARRAY_W;
      expect_word("x_tot_len_o", 32'(x_tot_len_o), exp_len);
      next_cycle();
    end
    x_leftover_i = '0;
    restart_walker(1'b1);
  endtask

  task automatic start_requests();
    tot_x_read_i = 16'd3;
    pulse_done();
    @(negedge clk_i);
    expect_bit("x_req_start_o", x_req_start_o, 1'b1);
    next_cycle();
    x_ready_start_i = 1'b0;
    @(negedge clk_i);
    expect_bit("x_req_start_o", x_req_start_o, 1'b0);
    next_cycle();
    x_ready_start_i = 1'b1;
    idle_i          = 1'b1;
    @(negedge clk_i);
    expect_bit("x_req_start_o", x_req_start_o, 1'b0);
    next_cycle();
    idle_i = 1'b0;
    pulse_done();
    next_cycle();
    pulse_done();
    // Read count now equals the total
    @(negedge clk_i);
    expect_bit("x_req_start_o", x_req_start_o, 1'b0);
    next_cycle();
    first_load_i = 1'b1;
    @(negedge clk_i);
    expect_requests(5'b11010);
    expect_word("w_base_addr_o", w_base_addr_o, w_addr_i);
    expect_bit("ignore_o", ignore_o, 1'b1);
    next_cycle();
    accumulate_i = 1'b1;
    dequant_en_i = 1'b1;
    @(negedge clk_i);
    expect_requests(5'b11111);
    expect_word("w_base_addr_o", w_base_addr_o, scales_addr_i);
    expect_bit("ignore_o", ignore_o, 1'b0);
    next_cycle();
    // Each stream waits for its own ready
    w_ready_start_i  = 1'b0;
    y_ready_start_i  = 1'b0;
    z_ready_start_i  = 1'b0;
    dq_ready_start_i = 1'b0;
    @(negedge clk_i);
    expect_requests(5'b10000);
    next_cycle();
    w_ready_start_i  = 1'b1;
    y_ready_start_i  = 1'b1;
    z_ready_start_i  = 1'b1;
    dq_ready_start_i = 1'b1;
    first_load_i     = 1'b0;
    accumulate_i     = 1'b0;
    dequant_en_i     = 1'b0;
    tot_x_read_i     = 16'd100;
    restart_walker(1'b0);
  endtask

  task automatic dequant_offsets();
    logic [ITER_W-1:0] strides [2];
    logic [GID_W:0]    gidxs [2];
    logic [ITER_W-1:0] rows [2];
    logic [31:0]       gidx_w;
    logic [31:0]       pk_stride;
    strides      = '{16'h0180, 16'h00FF};
    gidxs        = '{9'h005, 9'h1A3};
    rows         = '{16'h0021, 16'h0107};
    gidx_valid_i = 1'b1;
    row_valid_i  = 1'b1;
    for (int f = 0; f < 4; f++) begin
      for (int s = 0; s < 2; s++) begin
        for (int i = 0; i < 2; i++) begin
          qint_fmt_i    = qint_fmt_e'(f[1:0]);
          w_d0_stride_i = strides[s];
          gidx_data_i   = gidxs[i];
          row_data_i    = rows[i];
          gidx_w        = 32'(gidxs[i][GID_W-1:0]);
          pk_stride     = 32'(strides[s]) >> fmt_shift(qint_fmt_i);
          @(negedge clk_i);
          expect_handshake(4'b1111);
          expect_word("scales_offs_o", scales_offs_o, gidx_w * 32'(strides[s]));
          expect_word("zeros_offs_o", zeros_offs_o, gidx_w * pk_stride);
          expect_word("wq_offs_o", wq_offs_o, 32'(rows[i]) * pk_stride);
          expect_bit("gidx_skip_o", gidx_skip_o, gidxs[i][GID_W]);
          next_cycle();
        end
      end
    end
  endtask

  task automatic back_pressure();
    gidx_valid_i   = 1'b1;
    row_valid_i    = 1'b1;
    scales_ready_i = 1'b0;
    @(negedge clk_i);
    expect_handshake(4'b0011);
    next_cycle();
    scales_ready_i = 1'b1;
    zeros_ready_i  = 1'b0;
    @(negedge clk_i);
    expect_handshake(4'b0011);
    next_cycle();
    zeros_ready_i = 1'b1;
    wq_ready_i    = 1'b0;
    @(negedge clk_i);
    expect_handshake(4'b1100);
    next_cycle();
    wq_ready_i   = 1'b1;
    gidx_valid_i = 1'b0;
    row_valid_i  = 1'b0;
    @(negedge clk_i);
    expect_handshake(4'b0101);
    next_cycle();
  endtask

  initial begin
    rst_ni           = 1'b0;
    clear_i          = 1'b0;
    sched_rst_i      = 1'b0;
    x_addr_i         = 32'h1000_0000;
    x_col_iters_i    = 16'd3;
    x_row_iters_i    = 16'd2;
    w_iters_i        = 16'd2;
    x_rows_offs_i    = 32'h0000_0400;
    tot_x_read_i     = 16'd100;
    x_leftover_i     = '0;
    w_addr_i         = 32'h2000_0000;
    scales_addr_i    = 32'h3000_0000;
    w_d0_stride_i    = 16'h0180;
    accumulate_i     = 1'b0;
    dequant_en_i     = 1'b0;
    qint_fmt_i       = QINT_8;
    first_load_i     = 1'b0;
    idle_i           = 1'b0;
    x_done_i         = 1'b0;
    x_ready_start_i  = 1'b1;
    w_ready_start_i  = 1'b1;
    y_ready_start_i  = 1'b1;
    z_ready_start_i  = 1'b1;
    dq_ready_start_i = 1'b1;
    gidx_valid_i     = 1'b0;
    gidx_data_i      = '0;
    row_valid_i      = 1'b0;
    row_data_i       = '0;
    scales_ready_i   = 1'b1;
    zeros_ready_i    = 1'b1;
    wq_ready_i       = 1'b1;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    reset_state();
    column_walk();
    leftover_rows();
    start_requests();
    dequant_offsets();
    back_pressure();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/memory_scheduler_sva.sv */
// Concurrent checks on the offset handshakes and reset state, bound into the scheduler top level
`timescale 1ns/1ps
`default_nettype none

module memory_scheduler_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic gidx_valid_i,
  input logic row_valid_i,
  input logic scales_ready_i,
  input logic zeros_ready_i,
  input logic wq_ready_i,
  input logic gidx_ready_o,
  input logic gidx_offs_valid_o,
  input logic wq_valid_o,
  input logic x_req_start_o
);

  gidx_offs_gated: assert property (@(posedge clk_i) disable iff (!rst_ni)
    gidx_offs_valid_o |-> gidx_valid_i && scales_ready_i && zeros_ready_i)
    else $error("Scales/zeros offset valid without input valid and both readies");

  wq_offs_gated: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wq_valid_o |-> row_valid_i && wq_ready_i)
    else $error("Quantized-weight offset valid without row valid and ready");

  gidx_ready_joint: assert property (@(posedge clk_i) disable iff (!rst_ni)
    gidx_ready_o == (scales_ready_i && zeros_ready_i))
    else $error("Group index ready differs from the joint scales/zeros ready");

  // Nothing is loaded yet right after reset
  x_quiet_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> !x_req_start_o)
    else $error("X start request in the cycle after reset release");

endmodule

bind memory_scheduler memory_scheduler_sva i_sva (.*);

`default_nettype wire

/* design/memory_scheduler.sv */
// Top of the memory scheduler, connecting the X walker, stream launcher and dequant offset path
`timescale 1ns/1ps
`default_nettype none

module memory_scheduler (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         sched_rst_i,
  // Job configuration
  input  logic [sched_pkg::ADDR_W-1:0] x_addr_i,
  input  logic [sched_pkg::ITER_W-1:0] x_col_iters_i,
  input  logic [sched_pkg::ITER_W-1:0] x_row_iters_i,
  input  logic [sched_pkg::ITER_W-1:0] w_iters_i,
  input  logic [sched_pkg::ADDR_W-1:0] x_rows_offs_i,
  input  logic [sched_pkg::ITER_W-1:0] tot_x_read_i,
  input  logic [sched_pkg::LEN_W-1:0]  x_leftover_i,
  input  logic [sched_pkg::ADDR_W-1:0] w_addr_i,
  input  logic [sched_pkg::ADDR_W-1:0] scales_addr_i,
  input  logic [sched_pkg::ITER_W-1:0] w_d0_stride_i,
  input  logic                         accumulate_i,
  input  logic                         dequant_en_i,
  input  sched_pkg::qint_fmt_e         qint_fmt_i,
  input  logic                         first_load_i,
  input  logic                         idle_i,
  // Stream status
  input  logic                         x_done_i,
  input  logic                         x_ready_start_i,
  input  logic                         w_ready_start_i,
  input  logic                         y_ready_start_i,
  input  logic                         z_ready_start_i,
  input  logic                         dq_ready_start_i,
  // Index streams in
  input  logic                         gidx_valid_i,
  input  logic [sched_pkg::GID_W:0]    gidx_data_i,
  output logic                         gidx_ready_o,
  input  logic                         row_valid_i,
  input  logic [sched_pkg::ITER_W-1:0] row_data_i,
  output logic                         row_ready_o,
  // Offset streams out
  input  logic                         scales_ready_i,
  input  logic                         zeros_ready_i,
  input  logic                         wq_ready_i,
  output logic                         gidx_offs_valid_o,
  output logic [sched_pkg::ADDR_W-1:0] scales_offs_o,
  output logic [sched_pkg::ADDR_W-1:0] zeros_offs_o,
  output logic                         gidx_skip_o,
  output logic                         wq_valid_o,
  output logic [sched_pkg::ADDR_W-1:0] wq_offs_o,
  // X stream control
  output logic [sched_pkg::ADDR_W-1:0] x_base_addr_o,
  output logic [sched_pkg::LEN_W-1:0]  x_tot_len_o,
  // Start requests
  output logic                         x_req_start_o,
  output logic                         w_req_start_o,
  output logic                         y_req_start_o,
  output logic                         z_req_start_o,
  output logic                         dq_req_start_o,
  output logic [sched_pkg::ADDR_W-1:0] w_base_addr_o,
  output logic                         ignore_o
);

  logic x_reads_pending;

  x_tile_walker i_walker (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .clear_i           (clear_i),
    .sched_rst_i       (sched_rst_i),
    .x_done_i          (x_done_i),
    .x_addr_i          (x_addr_i),
    .x_col_iters_i     (x_col_iters_i),
    .x_row_iters_i     (x_row_iters_i),
    .w_iters_i         (w_iters_i),
    .x_rows_offs_i     (x_rows_offs_i),
    .tot_x_read_i      (tot_x_read_i),
    .x_leftover_i      (x_leftover_i),
    .x_base_addr_o     (x_base_addr_o),
    .x_tot_len_o       (x_tot_len_o),
    .x_reads_pending_o (x_reads_pending)
  );

  stream_launch i_launch (
    .first_load_i      (first_load_i),
    .idle_i            (idle_i),
    .x_reads_pending_i (x_reads_pending),
    .accumulate_i      (accumulate_i),
    .dequant_en_i      (dequant_en_i),
    .w_addr_i          (w_addr_i),
    .scales_addr_i     (scales_addr_i),
    .x_ready_start_i   (x_ready_start_i),
    .w_ready_start_i   (w_ready_start_i),
    .y_ready_start_i   (y_ready_start_i),
    .z_ready_start_i   (z_ready_start_i),
    .dq_ready_start_i  (dq_ready_start_i),
    .x_req_start_o     (x_req_start_o),
    .w_req_start_o     (w_req_start_o),
    .y_req_start_o     (y_req_start_o),
    .z_req_start_o     (z_req_start_o),
    .dq_req_start_o    (dq_req_start_o),
    .w_base_addr_o     (w_base_addr_o),
    .ignore_o          (ignore_o)
  );

  dequant_offset_gen i_offset_gen (
    .gidx_valid_i      (gidx_valid_i),
    .gidx_data_i       (gidx_data_i),
    .gidx_ready_o      (gidx_ready_o),
    .row_valid_i       (row_valid_i),
    .row_data_i        (row_data_i),
    .row_ready_o       (row_ready_o),
    .w_d0_stride_i     (w_d0_stride_i),
    .qint_fmt_i        (qint_fmt_i),
    .scales_ready_i    (scales_ready_i),
    .zeros_ready_i     (zeros_ready_i),
    .wq_ready_i        (wq_ready_i),
    .gidx_offs_valid_o (gidx_offs_valid_o),
    .scales_offs_o     (scales_offs_o),
    .zeros_offs_o      (zeros_offs_o),
    .gidx_skip_o       (gidx_skip_o),
    .wq_valid_o        (wq_valid_o),
    .wq_offs_o         (wq_offs_o)
  );

endmodule

`default_nettype wire

/* design/dequant_offset_gen.sv */
// Converts group and row indices into scales, zeros and quantized-weight address offsets
`timescale 1ns/1ps
`default_nettype none

module dequant_offset_gen (
  input  logic                         gidx_valid_i,
  input  logic [sched_pkg::GID_W:0]    gidx_data_i,
  output logic                         gidx_ready_o,
  input  logic                         row_valid_i,
  input  logic [sched_pkg::ITER_W-1:0] row_data_i,
  output logic                         row_ready_o,
  input  logic [sched_pkg::ITER_W-1:0] w_d0_stride_i,
  input  sched_pkg::qint_fmt_e         qint_fmt_i,
  input  logic                         scales_ready_i,
  input  logic                         zeros_ready_i,
  input  logic                         wq_ready_i,
  output logic                         gidx_offs_valid_o,
  output logic [sched_pkg::ADDR_W-1:0] scales_offs_o,
  output logic [sched_pkg::ADDR_W-1:0] zeros_offs_o,
  output logic                         gidx_skip_o,
  output logic                         wq_valid_o,
  output logic [sched_pkg::ADDR_W-1:0] wq_offs_o
);
  import sched_pkg::*;

  logic [1:0]        q_shift;
  logic [ITER_W-1:0] packed_stride;
  logic [ADDR_W-1:0] gidx_ext;
  logic [ADDR_W-1:0] row_ext;
  logic [ADDR_W-1:0] stride_ext;
  logic [ADDR_W-1:0] packed_stride_ext;
  logic              gidx_sink_rdy;

  // Narrower formats pack more weights per byte
  always_comb begin
    case (qint_fmt_i)
      QINT_2:  q_shift = 2'd3;
      QINT_4:  q_shift = 2'd2;
      default: q_shift = 2'd1;
    endcase
  end

  assign packed_stride = w_d0_stride_i >> q_shift;

  assign gidx_ext          = ADDR_W'(gidx_data_i[GID_W-1:0]);
  assign row_ext           = ADDR_W'(row_data_i);
  assign stride_ext        = ADDR_W'(w_d0_stride_i);
  assign packed_stride_ext = ADDR_W'(packed_stride);

  assign scales_offs_o = gidx_ext * stride_ext;
  assign zeros_offs_o  = gidx_ext * packed_stride_ext;
  assign wq_offs_o     = row_ext * packed_stride_ext;

  assign gidx_skip_o = gidx_data_i[GID_W];

  // Scales and zeros consume one group index together
  assign gidx_sink_rdy     = scales_ready_i && zeros_ready_i;
  assign gidx_ready_o      = gidx_sink_rdy;
  assign gidx_offs_valid_o = gidx_valid_i && gidx_sink_rdy;

  assign row_ready_o = wq_ready_i;
  assign wq_valid_o  = row_valid_i && wq_ready_i;

endmodule

`default_nettype wire

/* design/stream_launch.sv */
// Raises the stream start requests and picks the W base address from the dequantization mode
`timescale 1ns/1ps
`default_nettype none

module stream_launch (
  input  logic                         first_load_i,
  input  logic                         idle_i,
  input  logic                         x_reads_pending_i,
  input  logic                         accumulate_i,
  input  logic                         dequant_en_i,
  input  logic [sched_pkg::ADDR_W-1:0] w_addr_i,
  input  logic [sched_pkg::ADDR_W-1:0] scales_addr_i,
  input  logic                         x_ready_start_i,
  input  logic                         w_ready_start_i,
  input  logic                         y_ready_start_i,
  input  logic                         z_ready_start_i,
  input  logic                         dq_ready_start_i,
  output logic                         x_req_start_o,
  output logic                         w_req_start_o,
  output logic                         y_req_start_o,
  output logic                         z_req_start_o,
  output logic                         dq_req_start_o,
  output logic [sched_pkg::ADDR_W-1:0] w_base_addr_o,
  output logic                         ignore_o
);

  logic x_wanted;

  // X is reloaded for every tile, not only on the first load
  assign x_wanted = first_load_i | x_reads_pending_i;

  assign x_req_start_o = !idle_i && x_wanted && x_ready_start_i;

  // W, Y and Z are started once per job
  assign w_req_start_o = first_load_i && w_ready_start_i;
  assign z_req_start_o = first_load_i && z_ready_start_i;

  // Y holds the accumulation operand
  assign y_req_start_o = first_load_i && accumulate_i && y_ready_start_i;

  // Group index, zeros and quantized weights start together
  assign dq_req_start_o = dequant_en_i && first_load_i && dq_ready_start_i;

  // W port fetches the scales when dequantizing
  assign w_base_addr_o = dequant_en_i ? scales_addr_i : w_addr_i;

  // Offset and skip inputs of the streams unused without dequant
  assign ignore_o = !dequant_en_i;

endmodule

`default_nettype wire

/* design/x_tile_walker.sv */
// Walks the X operand tile by tile on stream completion and forms its base address and burst length
`timescale 1ns/1ps
`default_nettype none

module x_tile_walker (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         sched_rst_i,
  input  logic                         x_done_i,
  input  logic [sched_pkg::ADDR_W-1:0] x_addr_i,
  input  logic [sched_pkg::ITER_W-1:0] x_col_iters_i,
  input  logic [sched_pkg::ITER_W-1:0] x_row_iters_i,
  input  logic [sched_pkg::ITER_W-1:0] w_iters_i,
  input  logic [sched_pkg::ADDR_W-1:0] x_rows_offs_i,
  input  logic [sched_pkg::ITER_W-1:0] tot_x_read_i,
  input  logic [sched_pkg::LEN_W-1:0]  x_leftover_i,
  output logic [sched_pkg::ADDR_W-1:0] x_base_addr_o,
  output logic [sched_pkg::LEN_W-1:0]  x_tot_len_o,
  output logic                         x_reads_pending_o
);
  import sched_pkg::*;

  logic [ITER_W-1:0] col_iter_d, col_iter_q;
  logic [ITER_W-1:0] w_iter_d, w_iter_q;
  logic [ITER_W-1:0] row_iter_d, row_iter_q;
  logic [ITER_W-1:0] read_cnt_d, read_cnt_q;
  logic [ADDR_W-1:0] col_offs_d, col_offs_q;
  logic [ADDR_W-1:0] row_offs_d, row_offs_q;

  logic [ITER_W-1:0] col_max;
  logic [ITER_W-1:0] w_max;
  logic [ITER_W-1:0] row_max;
  logic              col_wrap;
  logic              w_wrap;
  logic              row_wrap;
  logic              flush;

  assign col_max  = x_col_iters_i - 1'b1;
  assign w_max    = w_iters_i - 1'b1;
  assign row_max  = x_row_iters_i - 1'b1;

  assign col_wrap = col_iter_q == col_max;
  assign w_wrap   = w_iter_q == w_max;
  assign row_wrap = row_iter_q == row_max;

  assign flush    = clear_i | sched_rst_i;

  // Column is innermost, then weight block, then row
  always_comb begin
    col_iter_d = col_iter_q;
    w_iter_d   = w_iter_q;
    row_iter_d = row_iter_q;
    read_cnt_d = read_cnt_q;
    col_offs_d = col_offs_q;
    row_offs_d = row_offs_q;
    if (x_done_i) begin
      col_iter_d = col_wrap ? '0 : col_iter_q + 1'b1;
      col_offs_d = col_wrap ? '0 : col_offs_q + MEM_JMP;
      read_cnt_d = read_cnt_q + 1'b1;
      if (col_wrap) begin
        w_iter_d = w_wrap ? '0 : w_iter_q + 1'b1;
        // Next row block only once every weight block has seen all columns
        if (w_wrap) begin
          row_iter_d = row_wrap ? '0 : row_iter_q + 1'b1;
          row_offs_d = row_wrap ? '0 : row_offs_q + x_rows_offs_i;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      col_iter_q <= '0;
      w_iter_q   <= '0;
      row_iter_q <= '0;
      read_cnt_q <= '0;
      col_offs_q <= '0;
      row_offs_q <= '0;
    end else if (flush) begin
      col_iter_q <= '0;
      w_iter_q   <= '0;
      row_iter_q <= '0;
      read_cnt_q <= '0;
      col_offs_q <= '0;
      row_offs_q <= '0;
    end else begin
      col_iter_q <= col_iter_d;
      w_iter_q   <= w_iter_d;
      row_iter_q <= row_iter_d;
      read_cnt_q <= read_cnt_d;
      col_offs_q <= col_offs_d;
      row_offs_q <= row_offs_d;
    end
  end

  assign x_base_addr_o = x_addr_i + row_offs_q + col_offs_q;

  // Last row block is short when the row count does not divide evenly
  assign x_tot_len_o = (row_wrap && (x_leftover_i != '0)) ? x_leftover_i : LEN_W'(ARRAY_W);

  // Reads remain while the count has started but not reached the total
  assign x_reads_pending_o = (read_cnt_q != '0) && (read_cnt_q != tot_x_read_i);

endmodule

`default_nettype wire

/* design/sched_pkg.sv */
// Shared widths, array geometry and integer-format encoding, imported by the scheduler RTL
`default_nettype none

package sched_pkg;

  // Address and offset width
  localparam int unsigned ADDR_W = 32;

  // Iteration counters and count fields
  localparam int unsigned ITER_W = 16;

  // Rows per full X burst with one row per array column
  localparam int unsigned ARRAY_W = 12;

  // Burst length must hold ARRAY_W itself
  localparam int unsigned LEN_W = $clog2(ARRAY_W) + 1;

  // Byte step between adjacent X column blocks
  localparam logic [ADDR_W-1:0] MEM_JMP = ADDR_W'(32);

  // Group index width with the skip flag in the bit above
  localparam int unsigned GID_W = 8;

  // Packed integer format of the quantized weights
  typedef enum logic [1:0] {
    QINT_8 = 2'b00,
    QINT_4 = 2'b01,
    QINT_2 = 2'b10
  } qint_fmt_e;

endpackage

`default_nettype wire
